/* hw/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int vertex_w = 32;
	localparam int edge_w   = 32;
	localparam int addr_w   = 32;
	localparam int data_w   = 64;
	localparam int cu_id_w  = 2;

	// id 0 marks a word with no owner
	localparam logic [cu_id_w-1:0] vertex_unit_id = 2'd1;
	localparam logic [cu_id_w-1:0] edge_unit_id   = 2'd2;

	// queued plus outstanding vertex reads never exceed this
	localparam int vertex_queue_depth = 4;

	//////////////////////////////
	// returned memory word
	//////////////////////////////
	typedef union packed {
		// vertex record from the vertex array
		struct packed {
			logic [edge_w-1:0] degree;
			logic [edge_w-1:0] edge_index;
		} vertex_view;
		// edge record from the edge array
		struct packed {
			logic [vertex_w-1:0]        dest_id;
			logic [data_w-vertex_w-1:0] weight;
		} edge_view;
	} read_word_t;

endpackage

`default_nettype wire

/* hw/cu_input_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_input_stage (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         enabled_in,
	input  wire  [63:0]                 cu_configure,
	input  wire                         wed_valid,
	input  wire  [cu_pkg::vertex_w-1:0] wed_num_vertices,
	input  wire  [cu_pkg::edge_w-1:0]   wed_num_edges,
	input  wire  [cu_pkg::addr_w-1:0]   wed_vertex_base,
	input  wire  [cu_pkg::addr_w-1:0]   wed_edge_base,
	input  wire                         read_data_valid,
	input  wire  [cu_pkg::cu_id_w-1:0]  read_data_cu_id,
	input  wire  cu_pkg::read_word_t    read_data,
	output logic                        enabled,
	output logic                        cu_ready,
	output logic [63:0]                 configure_q,
	output logic [cu_pkg::vertex_w-1:0] num_vertices,
	output logic [cu_pkg::edge_w-1:0]   num_edges,
	output logic [cu_pkg::addr_w-1:0]   vertex_base,
	output logic [cu_pkg::addr_w-1:0]   edge_base,
	output logic                        vertex_data_valid,
	output logic                        edge_data_valid,
	output cu_pkg::read_word_t          routed_data
);
	import cu_pkg::*;

	logic               wed_valid_q;
	logic               data_valid_q;
	logic [cu_id_w-1:0] data_cu_id_q;
	read_word_t         data_q;

	// unit may start once configured and given a descriptor
	assign cu_ready = (|configure_q) && wed_valid_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled           <= 1'b0;
			configure_q       <= '0;
			wed_valid_q       <= 1'b0;
			data_valid_q      <= 1'b0;
			vertex_data_valid <= 1'b0;
			edge_data_valid   <= 1'b0;
		end else begin
			enabled <= enabled_in;
			// a zero configuration word keeps the last one
			if (enabled && (|cu_configure)) begin
				configure_q <= cu_configure;
			end
			wed_valid_q       <= enabled ? wed_valid : wed_valid_q;
			data_valid_q      <= enabled && read_data_valid;
			// second stage steers the word to its owner
			vertex_data_valid <= enabled && data_valid_q && (data_cu_id_q == vertex_unit_id);
			edge_data_valid   <= enabled && data_valid_q && (data_cu_id_q == edge_unit_id);
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			num_vertices <= wed_num_vertices;
			num_edges    <= wed_num_edges;
			vertex_base  <= wed_vertex_base;
			edge_base    <= wed_edge_base;
			data_cu_id_q <= read_data_cu_id;
			data_q       <= read_data;
			routed_data  <= data_q;
		end
	end

	// every returned word must belong to a unit that issued the read
	assert property (@(posedge clock) disable iff (!rstn)
		data_valid_q |-> (data_cu_id_q != '0))
		else $error("returned data word carries unit id 0");

endmodule

`default_nettype wire

/* hw/cu_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_read_arbiter (
	input  wire                        clock,
	input  wire                        rstn,
	input  wire                        enabled,
	input  wire  [1:0]                 request,
	input  wire  [cu_pkg::addr_w-1:0]  address_vertex,
	input  wire  [cu_pkg::addr_w-1:0]  address_edge,
	input  wire                        read_buffer_full,
	output logic [1:0]                 grant,
	output logic                       read_command_valid,
	output logic [cu_pkg::cu_id_w-1:0] read_command_cu_id,
	output logic [cu_pkg::addr_w-1:0]  read_command_address
);
	import cu_pkg::*;

	// requester that has priority in the next contested cycle
	logic pointer;

	always_comb begin
		grant = '0;
		// back-pressure holds every request where it is
		if (enabled && !read_buffer_full) begin
			if (request[pointer]) begin
				grant[pointer] = 1'b1;
			end else if (request[!pointer]) begin
				grant[!pointer] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pointer            <= 1'b0;
			read_command_valid <= 1'b0;
		end else begin
			// priority moves past the winner
			if (|grant) begin
				pointer <= grant[0];
			end
			read_command_valid <= |grant;
		end
	end

	always_ff @(posedge clock) begin
		if (|grant) begin
			read_command_cu_id   <= grant[0] ? vertex_unit_id : edge_unit_id;
			read_command_address <= grant[0] ? address_vertex : address_edge;
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(grant) && ((grant & ~request) == '0))
		else $error("read grant is not one-hot or has no request");

endmodule

`default_nettype wire

/* hw/cu_vertex_job_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_job_control (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         cu_ready,
	input  wire  [cu_pkg::vertex_w-1:0] num_vertices,
	input  wire  [cu_pkg::addr_w-1:0]   vertex_base,
	input  wire                         vertex_data_valid,
	input  wire  cu_pkg::read_word_t    routed_data,
	input  wire                         grant,
	input  wire                         vertex_pop,
	output logic                        request,
	output logic [cu_pkg::addr_w-1:0]   address,
	output logic                        queue_valid,
	output cu_pkg::read_word_t          queue_record
);
	import cu_pkg::*;

	logic [vertex_w-1:0]                   next_vertex;
	logic [$clog2(vertex_queue_depth):0]   in_flight;
	logic [$clog2(vertex_queue_depth):0]   queue_count;
	logic [$clog2(vertex_queue_depth)-1:0] wr_ptr;
	logic [$clog2(vertex_queue_depth)-1:0] rd_ptr;
	read_word_t                            queue_mem [vertex_queue_depth];

	//////////////////////////////
	// read issue
	//////////////////////////////

	// a free queue slot is reserved for every read in flight
	assign request = cu_ready && (next_vertex < num_vertices) &&
		((in_flight + queue_count) < vertex_queue_depth);
	assign address = vertex_base + next_vertex;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_vertex <= '0;
			in_flight   <= '0;
		end else begin
			if (grant) begin
				next_vertex <= next_vertex + 1'b1;
			end
			if (grant && !vertex_data_valid) begin
				in_flight <= in_flight + 1'b1;
			end else if (!grant && vertex_data_valid) begin
				in_flight <= in_flight - 1'b1;
			end
		end
	end

	//////////////////////////////
	// vertex record queue
	//////////////////////////////

	assign queue_valid  = (queue_count != '0);
	assign queue_record = queue_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			queue_count <= '0;
		end else begin
			if (vertex_data_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (vertex_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (vertex_data_valid && !vertex_pop) begin
				queue_count <= queue_count + 1'b1;
			end else if (!vertex_data_valid && vertex_pop) begin
				queue_count <= queue_count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_data_valid) begin
			queue_mem[wr_ptr] <= routed_data;
		end
	end

	// credit check at issue time must leave room for every returned word
	assert property (@(posedge clock) disable iff (!rstn)
		vertex_data_valid |-> (queue_count < vertex_queue_depth))
		else $error("vertex record queue overflow");

endmodule

`default_nettype wire

/* hw/cu_vertex_job_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_job_filter (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         queue_valid,
	input  wire  cu_pkg::read_word_t    queue_record,
	input  wire                         vertex_request,
	output logic                        vertex_pop,
	output logic                        vertex_valid,
	output logic [cu_pkg::edge_w-1:0]   vertex_degree,
	output logic [cu_pkg::edge_w-1:0]   vertex_edge_index,
	output logic [cu_pkg::vertex_w-1:0] filtered_count
);

	// pull a record whenever the holding slot is free
	assign vertex_pop = queue_valid && !vertex_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid   <= 1'b0;
			filtered_count <= '0;
		end else begin
			if (vertex_pop) begin
				// zero-degree vertices need no edge work
				if (queue_record.vertex_view.degree == '0) begin
					filtered_count <= filtered_count + 1'b1;
				end else begin
					vertex_valid <= 1'b1;
				end
			end else if (vertex_request) begin
				vertex_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_pop) begin
			vertex_degree     <= queue_record.vertex_view.degree;
			vertex_edge_index <= queue_record.vertex_view.edge_index;
		end
	end

endmodule

`default_nettype wire

/* hw/cu_edge_job_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_edge_job_control (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         vertex_valid,
	input  wire  [cu_pkg::edge_w-1:0]   vertex_degree,
	input  wire  [cu_pkg::edge_w-1:0]   vertex_edge_index,
	input  wire  [cu_pkg::addr_w-1:0]   edge_base,
	input  wire                         edge_data_valid,
	input  wire  cu_pkg::read_word_t    routed_data,
	input  wire                         grant,
	output logic                        vertex_request,
	output logic                        request,
	output logic [cu_pkg::addr_w-1:0]   address,
	output logic [cu_pkg::vertex_w-1:0] vertices_done,
	output logic [cu_pkg::edge_w-1:0]   edges_done
);
	import cu_pkg::*;

	logic              busy;
	logic [edge_w-1:0] issue_left;
	logic [edge_w-1:0] return_left;

	// take the next vertex as soon as the previous one is finished
	assign vertex_request = !busy && vertex_valid;
	assign request        = busy && (issue_left != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy          <= 1'b0;
			issue_left    <= '0;
			return_left   <= '0;
			vertices_done <= '0;
			edges_done    <= '0;
		end else begin
			if (vertex_request) begin
				busy        <= 1'b1;
				issue_left  <= vertex_degree;
				return_left <= vertex_degree;
			end else begin
				if (grant) begin
					issue_left <= issue_left - 1'b1;
				end
				if (edge_data_valid) begin
					edges_done  <= edges_done + 1'b1;
					return_left <= return_left - 1'b1;
					// last edge of this vertex is back
					if (return_left == edge_w'(1)) begin
						busy          <= 1'b0;
						vertices_done <= vertices_done + 1'b1;
					end
				end
			end
		end
	end

	// edge records sit contiguously from the vertex's edge index
	always_ff @(posedge clock) begin
		if (vertex_request) begin
			address <= edge_base + vertex_edge_index;
		end else if (grant) begin
			address <= address + 1'b1;
		end
	end

	// edge words only come back for a vertex in progress
	assert property (@(posedge clock) disable iff (!rstn)
		edge_data_valid |-> busy && !$isunknown(routed_data.edge_view.dest_id))
		else $error("edge record returned with no vertex in progress");

endmodule

`default_nettype wire

/* hw/cu_done_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_done_control (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         cu_ready,
	input  wire  [63:0]                 configure_q,
	input  wire  [cu_pkg::vertex_w-1:0] num_vertices,
	input  wire  [cu_pkg::edge_w-1:0]   num_edges,
	input  wire  [cu_pkg::vertex_w-1:0] filtered_count,
	input  wire  [cu_pkg::vertex_w-1:0] vertices_done,
	input  wire  [cu_pkg::edge_w-1:0]   edges_done,
	output logic                        cu_done,
	output logic [cu_pkg::vertex_w-1:0] cu_return_vertices,
	output logic [cu_pkg::edge_w-1:0]   cu_return_edges,
	output logic [63:0]                 cu_status
);

	// filtered vertices count as processed
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return_vertices <= '0;
			cu_return_edges    <= '0;
			cu_status          <= '0;
		end else begin
			cu_return_vertices <= vertices_done + filtered_count;
			cu_return_edges    <= edges_done;
			cu_status          <= configure_q;
		end
	end

	assign cu_done = cu_ready && (cu_return_vertices == num_vertices) &&
		(cu_return_edges == num_edges);

endmodule

`default_nettype wire

/* hw/cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         enabled_in,
	input  wire  [63:0]                 cu_configure,
	input  wire                         wed_valid,
	input  wire  [cu_pkg::vertex_w-1:0] wed_num_vertices,
	input  wire  [cu_pkg::edge_w-1:0]   wed_num_edges,
	input  wire  [cu_pkg::addr_w-1:0]   wed_vertex_base,
	input  wire  [cu_pkg::addr_w-1:0]   wed_edge_base,
	input  wire                         read_buffer_full,
	input  wire                         read_data_valid,
	input  wire  [cu_pkg::cu_id_w-1:0]  read_data_cu_id,
	input  wire  cu_pkg::read_word_t    read_data,
	output logic                        read_command_valid,
	output logic [cu_pkg::cu_id_w-1:0]  read_command_cu_id,
	output logic [cu_pkg::addr_w-1:0]   read_command_address,
	output logic                        cu_done,
	output logic [cu_pkg::vertex_w-1:0] cu_return_vertices,
	output logic [cu_pkg::edge_w-1:0]   cu_return_edges,
	output logic [63:0]                 cu_status
);
	import cu_pkg::*;

	logic                enabled;
	logic                cu_ready;
	logic [63:0]         configure_q;
	logic [vertex_w-1:0] num_vertices;
	logic [edge_w-1:0]   num_edges;
	logic [addr_w-1:0]   vertex_base;
	logic [addr_w-1:0]   edge_base;
	logic                vertex_data_valid;
	logic                edge_data_valid;
	read_word_t          routed_data;

	// index 0 is the vertex unit, index 1 the edge unit
	logic [1:0]          request;
	logic [1:0]          grant;
	logic [addr_w-1:0]   address_vertex;
	logic [addr_w-1:0]   address_edge;

	logic                vertex_pop;
	logic                queue_valid;
	read_word_t          queue_record;
	logic                vertex_request;
	logic                vertex_valid;
	logic [edge_w-1:0]   vertex_degree;
	logic [edge_w-1:0]   vertex_edge_index;
	logic [vertex_w-1:0] filtered_count;
	logic [vertex_w-1:0] vertices_done;
	logic [edge_w-1:0]   edges_done;

	cu_input_stage input_stage_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.cu_configure      (cu_configure),
		.wed_valid         (wed_valid),
		.wed_num_vertices  (wed_num_vertices),
		.wed_num_edges     (wed_num_edges),
		.wed_vertex_base   (wed_vertex_base),
		.wed_edge_base     (wed_edge_base),
		.read_data_valid   (read_data_valid),
		.read_data_cu_id   (read_data_cu_id),
		.read_data         (read_data),
		.enabled           (enabled),
		.cu_ready          (cu_ready),
		.configure_q       (configure_q),
		.num_vertices      (num_vertices),
		.num_edges         (num_edges),
		.vertex_base       (vertex_base),
		.edge_base         (edge_base),
		.vertex_data_valid (vertex_data_valid),
		.edge_data_valid   (edge_data_valid),
		.routed_data       (routed_data)
	);

	cu_read_arbiter read_arbiter_i (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.request              (request),
		.address_vertex       (address_vertex),
		.address_edge         (address_edge),
		.read_buffer_full     (read_buffer_full),
		.grant                (grant),
		.read_command_valid   (read_command_valid),
		.read_command_cu_id   (read_command_cu_id),
		.read_command_address (read_command_address)
	);

	cu_vertex_job_control vertex_job_i (
		.clock             (clock),
		.rstn              (rstn),
		.cu_ready          (cu_ready),
		.num_vertices      (num_vertices),
		.vertex_base       (vertex_base),
		.vertex_data_valid (vertex_data_valid),
		.routed_data       (routed_data),
		.grant             (grant[0]),
		.vertex_pop        (vertex_pop),
		.request           (request[0]),
		.address           (address_vertex),
		.queue_valid       (queue_valid),
		.queue_record      (queue_record)
	);

	cu_vertex_job_filter vertex_filter_i (
		.clock             (clock),
		.rstn              (rstn),
		.queue_valid       (queue_valid),
		.queue_record      (queue_record),
		.vertex_request    (vertex_request),
		.vertex_pop        (vertex_pop),
		.vertex_valid      (vertex_valid),
		.vertex_degree     (vertex_degree),
		.vertex_edge_index (vertex_edge_index),
		.filtered_count    (filtered_count)
	);

	cu_edge_job_control edge_job_i (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_valid      (vertex_valid),
		.vertex_degree     (vertex_degree),
		.vertex_edge_index (vertex_edge_index),
		.edge_base         (edge_base),
		.edge_data_valid   (edge_data_valid),
		.routed_data       (routed_data),
		.grant             (grant[1]),
		.vertex_request    (vertex_request),
		.request           (request[1]),
		.address           (address_edge),
		.vertices_done     (vertices_done),
		.edges_done        (edges_done)
	);

	cu_done_control done_control_i (
		.clock              (clock),
		.rstn               (rstn),
		.cu_ready           (cu_ready),
		.configure_q        (configure_q),
		.num_vertices       (num_vertices),
		.num_edges          (num_edges),
		.filtered_count     (filtered_count),
		.vertices_done      (vertices_done),
		.edges_done         (edges_done),
		.cu_done            (cu_done),
		.cu_return_vertices (cu_return_vertices),
		.cu_return_edges    (cu_return_edges),
		.cu_status          (cu_status)
	);

endmodule

`default_nettype wire

/* verif/cu_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_memory_model #(
	parameter int          vertex_count = 24,
	parameter logic [31:0] vertex_base  = 32'h0000_1000,
	parameter logic [31:0] edge_base    = 32'h0001_0000
) (
	input  wire                        clock,
	input  wire                        read_command_valid,
	input  wire  [cu_pkg::cu_id_w-1:0] read_command_cu_id,
	input  wire  [cu_pkg::addr_w-1:0]  read_command_address,
	output logic                       read_buffer_full,
	output logic                       read_data_valid,
	output logic [cu_pkg::cu_id_w-1:0] read_data_cu_id,
	output cu_pkg::read_word_t         read_data,
	output logic [cu_pkg::edge_w-1:0]  total_edges
);
	import cu_pkg::*;

	logic [edge_w-1:0]  degree     [vertex_count];
	logic [edge_w-1:0]  edge_index [vertex_count];
	logic [31:0]        rnd;
	// response pipe whose stage 2 goes out next
	logic               pipe_valid [3];
	logic [cu_id_w-1:0] pipe_id    [3];
	read_word_t         pipe_word  [3];

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// the vertex array answers in the vertex view and the edge array in the edge view
	function automatic read_word_t memory_word(input logic [addr_w-1:0] address);
		read_word_t        word;
		logic [addr_w-1:0] offset;
		word = '0;
		if (address >= vertex_base && address < vertex_base + vertex_count) begin
			offset = address - vertex_base;
			word.vertex_view.degree     = degree[offset];
			word.vertex_view.edge_index = edge_index[offset];
		end else if (address >= edge_base && address < edge_base + total_edges) begin
			offset = address - edge_base;
			word.edge_view.dest_id = (offset * 7) % vertex_count;
			word.edge_view.weight  = offset ^ 32'h0000_5a5a;
		end
		return word;
	endfunction

	initial begin
		read_buffer_full = 1'b0;
		read_data_valid  = 1'b0;
		read_data_cu_id  = '0;
		read_data        = '0;
		for (int s = 0; s < 3; s++) begin
			pipe_valid[s] = 1'b0;
			pipe_id[s]    = '0;
			pipe_word[s]  = '0;
		end
		// graph with degrees 0..3 and contiguous edge lists
		rnd         = 32'd15451;
		total_edges = '0;
		for (int v = 0; v < vertex_count; v++) begin
			rnd           = xorshift32(rnd);
			degree[v]     = rnd % 4;
			edge_index[v] = total_edges;
			total_edges   = total_edges + degree[v];
		end
		forever begin
			@(negedge clock);
			for (int s = 2; s > 0; s--) begin
				pipe_valid[s] = pipe_valid[s-1];
				pipe_id[s]    = pipe_id[s-1];
				pipe_word[s]  = pipe_word[s-1];
			end
			pipe_valid[0] = read_command_valid;
			pipe_id[0]    = read_command_cu_id;
			pipe_word[0]  = read_command_valid ? memory_word(read_command_address) : '0;
			@(posedge clock);
			#2;
			rnd              = xorshift32(rnd);
			read_buffer_full = (rnd[2:0] == 3'd0);
			read_data_valid  = pipe_valid[2];
			read_data_cu_id  = pipe_id[2];
			read_data        = pipe_word[2];
		end
	end

endmodule

`default_nettype wire

/* verif/cu_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_tb;
	import cu_pkg::*;

	localparam int                vertex_count     = 24;
	localparam logic [addr_w-1:0] vertex_base_addr = 32'h0000_1000;
	localparam logic [addr_w-1:0] edge_base_addr   = 32'h0001_0000;
	localparam logic [63:0]       config_word      = 64'h0000_0003_0000_0011;
	localparam int                cycle_limit      = vertex_count * 4 * 20 + 500;

	logic                clock;
	logic                rstn;
	logic                enabled_in;
	logic [63:0]         cu_configure;
	logic                wed_valid;
	logic [vertex_w-1:0] wed_num_vertices;
	logic [edge_w-1:0]   wed_num_edges;
	logic [addr_w-1:0]   wed_vertex_base;
	logic [addr_w-1:0]   wed_edge_base;
	logic                read_buffer_full;
	logic                read_data_valid;
	logic [cu_id_w-1:0]  read_data_cu_id;
	read_word_t          read_data;
	logic                read_command_valid;
	logic [cu_id_w-1:0]  read_command_cu_id;
	logic [addr_w-1:0]   read_command_address;
	logic                cu_done;
	logic [vertex_w-1:0] cu_return_vertices;
	logic [edge_w-1:0]   cu_return_edges;
	logic [63:0]         cu_status;
	logic [edge_w-1:0]   total_edges;

	logic config_applied;
	logic status_armed;
	int   cycle_count = 0;
	int   vertex_cmds;
	int   edge_cmds;

	cu_control dut_i (.*);

	cu_memory_model #(
		.vertex_count (vertex_count),
		.vertex_base  (vertex_base_addr),
		.edge_base    (edge_base_addr)
	) memory_i (.*);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic expect_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		assert (got === expected)
			else report_failure($sformatf("mismatch %s: got %h expected %h", name, got, expected));
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// command tracking and timeout
	//////////////////////////////
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_cmds <= 0;
			edge_cmds   <= 0;
		end else if (read_command_valid) begin
			if (read_command_cu_id == vertex_unit_id) begin
				vertex_cmds <= vertex_cmds + 1;
			end else begin
				edge_cmds <= edge_cmds + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			report_failure($sformatf("timeout, cu_done not raised within %0d cycles", cycle_limit));
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////
	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |-> config_applied)
		else report_failure("read command issued before any nonzero configuration");

	// back-pressure blocks the command of the following cycle
	assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_full |=> !read_command_valid)
		else report_failure("read command issued right after read_buffer_full was high");

	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |->
		(read_command_cu_id == vertex_unit_id || read_command_cu_id == edge_unit_id))
		else report_failure("read command carries an unknown unit id");

	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid && read_command_cu_id == vertex_unit_id |-> vertex_cmds < vertex_count)
		else report_failure("more vertex reads issued than there are vertices");

	// vertex records are read one word after another from the base
	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid && read_command_cu_id == vertex_unit_id |->
		read_command_address == vertex_base_addr + vertex_cmds)
		else report_failure($sformatf("mismatch read_command_address: got %h expected %h",
			$sampled(read_command_address), vertex_base_addr + $sampled(vertex_cmds)));

	assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid && read_command_cu_id == edge_unit_id |->
		read_command_address >= edge_base_addr &&
		read_command_address < edge_base_addr + total_edges)
		else report_failure($sformatf("edge read address %h lies outside the edge array",
			$sampled(read_command_address)));

	assert property (@(posedge clock) disable iff (!rstn)
		status_armed |-> cu_status == config_word)
		else report_failure($sformatf("mismatch cu_status: got %h expected %h",
			$sampled(cu_status), config_word));

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		rstn             = 1'b0;
		enabled_in       = 1'b0;
		cu_configure     = '0;
		wed_valid        = 1'b0;
		wed_num_vertices = '0;
		wed_num_edges    = '0;
		wed_vertex_base  = '0;
		wed_edge_base    = '0;
		config_applied   = 1'b0;
		status_armed     = 1'b0;
		repeat (10) @(posedge clock);
		#2;
		rstn = 1'b1;
		@(negedge clock);
		expect_value("read_command_valid", read_command_valid, 0);
		expect_value("cu_done", cu_done, 0);
		expect_value("cu_return_vertices", cu_return_vertices, 0);
		expect_value("cu_return_edges", cu_return_edges, 0);
		// descriptor first while the configuration is still zero
		@(posedge clock);
		#2;
		enabled_in       = 1'b1;
		wed_valid        = 1'b1;
		wed_num_vertices = vertex_count;
		wed_num_edges    = total_edges;
		wed_vertex_base  = vertex_base_addr;
		wed_edge_base    = edge_base_addr;
		repeat (20) @(posedge clock);
		#2;
		cu_configure   = config_word;
		config_applied = 1'b1;
		@(posedge clock);
		#2;
		cu_configure = '0;
		// status lags the input by two registers
		repeat (4) @(posedge clock);
		#2;
		status_armed = 1'b1;
		do begin
			@(negedge clock);
		end while (cu_done !== 1'b1);
		expect_value("cu_return_vertices", cu_return_vertices, vertex_count);
		expect_value("cu_return_edges", cu_return_edges, total_edges);
		expect_value("edge read commands", edge_cmds, total_edges);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/cu_pkg.sv
hw/cu_input_stage.sv
hw/cu_read_arbiter.sv
hw/cu_vertex_job_control.sv
hw/cu_vertex_job_filter.sv
hw/cu_edge_job_control.sv
hw/cu_done_control.sv
hw/cu_control.sv
verif/cu_memory_model.sv
verif/cu_control_tb.sv

/* Bender.yml */
package:
  name: cu_control

dependencies: {}

sources:
  - hw/cu_pkg.sv
  - hw/cu_input_stage.sv
  - hw/cu_read_arbiter.sv
  - hw/cu_vertex_job_control.sv
  - hw/cu_vertex_job_filter.sv
  - hw/cu_edge_job_control.sv
  - hw/cu_done_control.sv
  - hw/cu_control.sv
  - target: test
    files:
      - verif/cu_memory_model.sv
      - verif/cu_control_tb.sv
